// File: bench/zr_csr_chk.sv
//////////////////////////////////////////////////
// concurrent assertions bound onto the CSR top level
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "zr_csr_settings.svh"

module zr_csr_chk (
  input  logic                                clk,
  input  logic                                rst_n,
  input  zr_csr_pkg::csr_req_t                csr_req_i,
  input  logic [`ZR_XLEN-1:0]                 rdata_i,
  input  zr_csr_pkg::trap_ctrl_t              trap_i,
  input  logic                                irq_en_i,
  input  logic [1:0]                          pcmr_i,
  input  zr_csr_pkg::csr_wen_t                wen_i,
  input  logic [`ZR_N_PERF-1:0][`ZR_XLEN-1:0] pccr_i
);

  int n_fail = 0;  // failed assertions so far

  // idle port reads zero right after reset release
  a_idle_read_zero: assert property (@(posedge clk)
    $rose(rst_n) |=> (csr_req_i.access || (rdata_i == '0)))
    else begin
      n_fail++;
      $error("read data not zero after reset with access low");
    end

  // trap entry disables interrupts
  a_trap_irq_off: assert property (@(posedge clk) disable iff (!rst_n)
    trap_i.save_cause |=> !irq_en_i)
    else begin
      n_fail++;
      $error("interrupt enable still set after trap save");
    end

  for (genvar i = 0; i < `ZR_N_PERF; i++) begin : g_sat
    a_sat_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (pcmr_i[1] && (&pccr_i[i]) && !wen_i.pccr[i]) |=> (&pccr_i[i]))
      else begin
        n_fail++;
        $error("saturated counter %0d left all ones", i);
      end
  end

endmodule

bind zr_csr_top zr_csr_chk u_chk (
  .clk (clk), .rst_n (rst_n), .csr_req_i (csr_req_i), .rdata_i (csr_rdata_o),
  .trap_i (trap_i), .irq_en_i (m_irq_enable_o), .pcmr_i (pcmr), .wen_i (wen),
  .pccr_i (pccr)
);

// File: bench/zr_csr_tb.sv
//////////////////////////////////////////////////
// directed testbench of the machine CSR unit, runs
// six tests on the top level and prints a summary
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "zr_csr_settings.svh"

module zr_csr_tb;

  localparam int WATCHDOG_CYCLES = 2000;  // reset + six tests, each well under 300 cycles
  localparam int N_TESTS         = 6;

  logic                     clk;
  logic                     rst_n;
  zr_csr_pkg::csr_req_t     csr_req;
  zr_csr_pkg::trap_ctrl_t   trap;
  zr_csr_pkg::perf_event_t  perf_evt;
  logic [`ZR_XLEN-1:0]      pc_if, pc_id;
  logic [`ZR_BOOT_W-1:0]    boot_addr;
  logic [3:0]               core_id;
  logic [5:0]               cluster_id;
  logic [`ZR_XLEN-1:0]      csr_rdata;
  logic                     m_irq_enable;
  logic [`ZR_XLEN-1:0]      mepc;
  int                       errors, checks, errs_at_start;

  zr_csr_top DUT (
    .clk (clk), .rst_n (rst_n), .csr_req_i (csr_req), .trap_i (trap),
    .perf_evt_i (perf_evt), .pc_if_i (pc_if), .pc_id_i (pc_id),
    .boot_addr_i (boot_addr), .core_id_i (core_id), .cluster_id_i (cluster_id),
    .csr_rdata_o (csr_rdata), .m_irq_enable_o (m_irq_enable), .mepc_o (mepc)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired, the tests did not finish in time");
    $display("TB FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // helpers
  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  function automatic zr_csr_pkg::csr_req_t make_req(input zr_csr_pkg::csr_op_e op,
                                                    input logic [11:0] addr,
                                                    input logic [31:0] wdata);
    make_req        = '0;
    make_req.access = 1'b1;
    make_req.addr   = addr;
    make_req.op     = op;
    make_req.wdata  = wdata;
  endfunction

  // expected result of an op, from the write/set/clear rules
  function automatic logic [31:0] apply_op(input zr_csr_pkg::csr_op_e op,
                                           input logic [31:0] old, input logic [31:0] wd);
    case (op)
      zr_csr_pkg::CSR_OP_WRITE: apply_op = wd;
      zr_csr_pkg::CSR_OP_SET:   apply_op = old | wd;
      zr_csr_pkg::CSR_OP_CLEAR: apply_op = old & ~wd;
      default:                  apply_op = old;
    endcase
  endfunction

  function automatic logic [31:0] mstatus_exp(input logic mie, input logic mpie);
    mstatus_exp = 32'h0000_1800 | {24'b0, mpie, 3'b0, mie, 3'b0};  // mpp = machine
  endfunction

  // one cycle of trap command and request, then back to idle
  task automatic drive_cycle(input zr_csr_pkg::trap_ctrl_t cmd, input zr_csr_pkg::csr_req_t req);
    @(posedge clk); #5;
    trap    = cmd;
    csr_req = req;
    @(posedge clk); #5;
    trap    = '0;
    csr_req = '0;
  endtask

  task automatic csr_write(input zr_csr_pkg::csr_op_e op, input logic [11:0] addr,
                           input logic [31:0] wdata);
    drive_cycle('0, make_req(op, addr, wdata));
  endtask

  task automatic read_csr(input logic [11:0] addr, output logic [31:0] got);
    @(posedge clk); #5;
    csr_req = make_req(zr_csr_pkg::CSR_OP_NONE, addr, '0);
    @(negedge clk);
    got = csr_rdata;  // mid cycle, read path settled
    @(posedge clk); #5;
    csr_req = '0;
  endtask

  task automatic read_check(input logic [11:0] addr, input string name, input logic [31:0] exp);
    logic [31:0] got;
    read_csr(addr, got);
    check(name, got, exp);
  endtask

  task automatic pulse_event(input zr_csr_pkg::perf_event_t evt);
    @(posedge clk); #5;
    perf_evt = evt;
    @(posedge clk); #5;
    perf_evt = '0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
    #5;
  endtask

  task automatic end_test(input string name);
    $display("test %s done, %0d errors", name, errors - errs_at_start);
    errs_at_start = errors;
  endtask

  //////////////////////////////////////////////////
  // directed tests
  task automatic test_reset_values();
    read_check(`ZR_CSR_MSTATUS, "mstatus", 32'h0000_1800);
    read_check(`ZR_CSR_PCER, "pcer", 32'h0);
    read_check(`ZR_CSR_PCMR, "pcmr", 32'h3);  // enabled, saturating
    read_check(`ZR_CSR_MTVEC, "mtvec", 32'(boot_addr) << 8);
    read_check(`ZR_CSR_MHARTID, "mhartid", (32'(cluster_id) << 5) | 32'(core_id));
    read_check(`ZR_CSR_MEPC, "mepc", 32'h0);
    read_check(`ZR_CSR_MCAUSE, "mcause", 32'h0);
    check("m_irq_enable_o", {31'b0, m_irq_enable}, 32'h0);
    end_test("reset_values");
  endtask

  task automatic test_sw_ops();
    zr_csr_pkg::csr_op_e ops [4];
    logic [31:0]         v, st, exp_epc;
    logic                mie, mpie;
    ops     = '{zr_csr_pkg::CSR_OP_WRITE, zr_csr_pkg::CSR_OP_SET,
                zr_csr_pkg::CSR_OP_CLEAR, zr_csr_pkg::CSR_OP_NONE};
    exp_epc = '0;
    mie     = 1'b0;
    mpie    = 1'b0;
    for (int k = 0; k < 4; k++) begin
      v = $urandom;
      csr_write(ops[k], `ZR_CSR_MEPC, v);
      exp_epc = apply_op(ops[k], exp_epc, v);
      read_check(`ZR_CSR_MEPC, "mepc", exp_epc);
      check("mepc_o", mepc, exp_epc);
      v = $urandom;
      csr_write(ops[k], `ZR_CSR_MSTATUS, v);
      st   = apply_op(ops[k], mstatus_exp(mie, mpie), v);  // only mie, mpie stick
      mie  = st[3];
      mpie = st[7];
      read_check(`ZR_CSR_MSTATUS, "mstatus", mstatus_exp(mie, mpie));
      check("m_irq_enable_o", {31'b0, m_irq_enable}, {31'b0, mie});
    end
    end_test("sw_ops");
  endtask

  task automatic test_trap();
    zr_csr_pkg::trap_ctrl_t cmd;
    zr_csr_pkg::trap_ctrl_t mret;
    logic [31:0]            junk;
    pc_if = $urandom;
    pc_id = $urandom;
    junk  = $urandom;
    mret  = '0;
    mret.restore_mret = 1'b1;
    csr_write(zr_csr_pkg::CSR_OP_WRITE, `ZR_CSR_MSTATUS, 32'h8);  // mie on
    // save from IF, software write to mepc in the same cycle
    cmd = '0;
    cmd.save_cause = 1'b1;
    cmd.save_if    = 1'b1;
    cmd.cause      = 6'h23;
    drive_cycle(cmd, make_req(zr_csr_pkg::CSR_OP_WRITE, `ZR_CSR_MEPC, junk));
    check("mepc_o", mepc, pc_if);
    check("m_irq_enable_o", {31'b0, m_irq_enable}, 32'h0);
    read_check(`ZR_CSR_MSTATUS, "mstatus", mstatus_exp(1'b0, 1'b1));
    read_check(`ZR_CSR_MCAUSE, "mcause", 32'h8000_0003);  // flag at 31, code 3
    drive_cycle(mret, '0);
    read_check(`ZR_CSR_MSTATUS, "mstatus", mstatus_exp(1'b1, 1'b1));
    check("m_irq_enable_o", {31'b0, m_irq_enable}, 32'h1);
    // save from ID
    cmd = '0;
    cmd.save_cause = 1'b1;
    cmd.save_id    = 1'b1;
    cmd.cause      = 6'h0b;
    drive_cycle(cmd, make_req(zr_csr_pkg::CSR_OP_WRITE, `ZR_CSR_MEPC, junk));
    check("mepc_o", mepc, pc_id);
    read_check(`ZR_CSR_MCAUSE, "mcause", 32'h0000_000b);
    read_check(`ZR_CSR_MSTATUS, "mstatus", mstatus_exp(1'b0, 1'b1));
    drive_cycle(mret, '0);
    read_check(`ZR_CSR_MSTATUS, "mstatus", mstatus_exp(1'b1, 1'b1));
    // trap with irqs off stacks a zero, mret then pops it and sets mpie
    csr_write(zr_csr_pkg::CSR_OP_WRITE, `ZR_CSR_MSTATUS, 32'h0);
    drive_cycle(cmd, '0);
    read_check(`ZR_CSR_MSTATUS, "mstatus", mstatus_exp(1'b0, 1'b0));
    drive_cycle(mret, '0);
    read_check(`ZR_CSR_MSTATUS, "mstatus", mstatus_exp(1'b0, 1'b1));
    check("m_irq_enable_o", {31'b0, m_irq_enable}, 32'h0);
    end_test("trap");
  endtask

  task automatic test_counting();
    zr_csr_pkg::perf_event_t evt;
    int                      n;
    csr_write(zr_csr_pkg::CSR_OP_WRITE, `ZR_CSR_PCER, 32'h4);  // load counter only
    csr_write(zr_csr_pkg::CSR_OP_WRITE, `ZR_CSR_PCMR, 32'h1);
    n   = $urandom_range(12, 3);
    evt = '0;
    evt.mem_load  = 1'b1;
    evt.mem_store = 1'b1;  // store counter is off
    repeat (n) pulse_event(evt);
    idle(3);  // request stage + counter stage
    read_check(`ZR_CSR_PCCR_BASE + 12'd2, "pccr_load", 32'(n));
    read_check(`ZR_CSR_PCCR_BASE + 12'd3, "pccr_store", 32'h0);
    read_check(`ZR_CSR_PCCR_BASE, "pccr_cycles", 32'h0);
    end_test("counting");
  endtask

  task automatic test_saturation();
    zr_csr_pkg::perf_event_t evt;
    evt = '0;
    evt.mem_load = 1'b1;
    csr_write(zr_csr_pkg::CSR_OP_WRITE, `ZR_CSR_PCMR, 32'h3);
    csr_write(zr_csr_pkg::CSR_OP_WRITE, `ZR_CSR_PCCR_BASE + 12'd2, 32'hffff_ffff);
    repeat (3) pulse_event(evt);
    idle(3);
    read_check(`ZR_CSR_PCCR_BASE + 12'd2, "pccr_load", 32'hffff_ffff);
    csr_write(zr_csr_pkg::CSR_OP_WRITE, `ZR_CSR_PCMR, 32'h1);  // wrap mode
    pulse_event(evt);
    idle(3);
    read_check(`ZR_CSR_PCCR_BASE + 12'd2, "pccr_load", 32'h0);
    end_test("saturation");
  endtask

  task automatic test_all_write();
    zr_csr_pkg::perf_event_t evt;
    logic [31:0]             cyc;
    evt = '1;  // every event once, so no counter sits at zero
    csr_write(zr_csr_pkg::CSR_OP_WRITE, `ZR_CSR_PCER, 32'h3f);
    csr_write(zr_csr_pkg::CSR_OP_WRITE, `ZR_CSR_PCMR, 32'h1);
    pulse_event(evt);
    idle(3);
    read_csr(`ZR_CSR_PCCR_BASE, cyc);
    check("pccr_cycles running", {31'b0, cyc != 32'h0}, 32'h1);
    csr_write(zr_csr_pkg::CSR_OP_WRITE, `ZR_CSR_PCMR, 32'h0);  // global enable off
    idle(3);  // let pending requests drain
    csr_write(zr_csr_pkg::CSR_OP_WRITE, `ZR_CSR_PCCR_ALL, 32'h0);
    for (int i = 0; i < `ZR_N_PERF; i++) begin
      read_check(`ZR_CSR_PCCR_BASE + 12'(i), $sformatf("pccr[%0d]", i), 32'h0);
    end
    end_test("all_write");
  endtask

  //////////////////////////////////////////////////
  // main sequence
  initial begin
    void'($urandom(32'hf01b80e2));
    errors        = 0;
    checks        = 0;
    errs_at_start = 0;
    rst_n         = 1'b0;
    csr_req       = '0;
    csr_req.addr  = `ZR_CSR_MSTATUS;  // idle port on a nonzero register
    trap          = '0;
    perf_evt      = '0;
    pc_if         = '0;
    pc_id         = '0;
    boot_addr     = 24'h1c_0080;
    core_id       = 4'h5;
    cluster_id    = 6'h2b;
    repeat (16) @(posedge clk);
    #5;
    rst_n = 1'b1;
    idle(1);  // access stays low in the first cycle after reset

    test_reset_values();
    test_sw_ops();
    test_trap();
    test_counting();
    test_saturation();
    test_all_write();

    errors = errors + DUT.u_chk.n_fail;
    $display("%0d tests, %0d checks, %0d errors", N_TESTS, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the CSR unit testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module zr_csr_tb \
  -f zr_csr.f --Mdir "$BUILD" -o zr_csr_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD/zr_csr_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
  exit 0
fi
exit 1

// File: source/csr_access_unit.sv
//////////////////////////////////////////////////
// software side of the CSR unit: address decode,
// read mux and write/set/clear data with strobes
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "zr_csr_settings.svh"

module csr_access_unit (
  input  zr_csr_pkg::csr_req_t                     csr_req_i,
  input  zr_csr_pkg::mach_view_t                   mach_i,
  input  logic [`ZR_N_PERF-1:0]                    pcer_i,
  input  logic [1:0]                               pcmr_i,
  input  logic [`ZR_N_PERF-1:0][`ZR_XLEN-1:0]      pccr_i,
  input  logic [`ZR_BOOT_W-1:0]                    boot_addr_i,
  input  logic [3:0]                               core_id_i,
  input  logic [5:0]                               cluster_id_i,
  output zr_csr_pkg::csr_wen_t                     wen_o,
  output logic [`ZR_XLEN-1:0]                      wdata_o,
  output logic [`ZR_XLEN-1:0]                      rdata_o
);

  localparam logic [`ZR_ADDR_W-1:0] PCCR_BASE = `ZR_CSR_PCCR_BASE;

  logic [`ZR_XLEN-1:0]   rback;     // value of the addressed register
  logic [`ZR_N_PERF-1:0] pccr_hit;  // single counter selected
  logic [4:0]            pccr_idx;
  logic                  in_pccr;   // inside the 0x780..0x79F window
  logic                  all_sel;
  logic                  do_wr;

  assign pccr_idx = csr_req_i.addr[4:0];
  assign in_pccr  = (csr_req_i.addr[`ZR_ADDR_W-1:5] == PCCR_BASE[`ZR_ADDR_W-1:5]);
  assign all_sel  = (csr_req_i.addr == `ZR_CSR_PCCR_ALL);
  assign do_wr    = csr_req_i.access && (csr_req_i.op != zr_csr_pkg::CSR_OP_NONE);

  //////////////////////////////////////////////////
  // readback
  always_comb begin
    rback    = '0;  // unmapped reads as zero
    pccr_hit = '0;
    case (csr_req_i.addr)
      `ZR_CSR_MSTATUS: rback = {19'b0, zr_csr_pkg::PRIV_LVL_M, 3'b0, mach_i.mpie,
                                3'b0, mach_i.mie, 3'b0};
      `ZR_CSR_MTVEC:   rback = {boot_addr_i, {(`ZR_XLEN-`ZR_BOOT_W){1'b0}}};
      `ZR_CSR_MEPC:    rback = mach_i.mepc;
      `ZR_CSR_MCAUSE:  rback = {mach_i.mcause[5], 26'b0, mach_i.mcause[4:0]};
      `ZR_CSR_MHARTID: rback = {21'b0, cluster_id_i, 1'b0, core_id_i};
      `ZR_CSR_PCER:    rback = {{(`ZR_XLEN-`ZR_N_PERF){1'b0}}, pcer_i};
      `ZR_CSR_PCMR:    rback = {30'b0, pcmr_i};
      default: begin
        // 0x79F is in the window too but matches no index, so reads 0
        for (int i = 0; i < `ZR_N_PERF; i++) begin
          if (in_pccr && (pccr_idx == 5'(i))) begin
            pccr_hit[i] = 1'b1;
            rback       = pccr_i[i];
          end
        end
      end
    endcase
  end

  assign rdata_o = csr_req_i.access ? rback : '0;  // idle port reads zero

  // effective write data, set/clear act on the readback
  always_comb begin
    unique case (csr_req_i.op)
      zr_csr_pkg::CSR_OP_SET:   wdata_o = rback | csr_req_i.wdata;
      zr_csr_pkg::CSR_OP_CLEAR: wdata_o = rback & ~csr_req_i.wdata;
      default:                  wdata_o = csr_req_i.wdata;  // write, none
    endcase
  end

  //////////////////////////////////////////////////
  // write strobes
  always_comb begin
    wen_o.mstatus = do_wr && (csr_req_i.addr == `ZR_CSR_MSTATUS);
    wen_o.mepc    = do_wr && (csr_req_i.addr == `ZR_CSR_MEPC);
    wen_o.mcause  = do_wr && (csr_req_i.addr == `ZR_CSR_MCAUSE);
    wen_o.pcer    = do_wr && (csr_req_i.addr == `ZR_CSR_PCER);
    wen_o.pcmr    = do_wr && (csr_req_i.addr == `ZR_CSR_PCMR);
    wen_o.pccr    = {`ZR_N_PERF{do_wr}} & (pccr_hit | {`ZR_N_PERF{all_sel}});
  end

endmodule

// File: source/machine_csr_regs.sv
//////////////////////////////////////////////////
// mstatus, mepc and mcause storage, merges software
// writes with trap entry and mret
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "zr_csr_settings.svh"

module machine_csr_regs (
  input  logic                     clk,
  input  logic                     rst_n,
  input  zr_csr_pkg::csr_wen_t     wen_i,
  input  logic [`ZR_XLEN-1:0]      wdata_i,
  input  zr_csr_pkg::trap_ctrl_t   trap_i,
  input  logic [`ZR_XLEN-1:0]      pc_if_i,
  input  logic [`ZR_XLEN-1:0]      pc_id_i,
  output zr_csr_pkg::mach_view_t   mach_o
);

  // state, mpp is fixed to machine and not stored
  logic                   mie_q, mie_d;
  logic                   mpie_q, mpie_d;
  logic [`ZR_XLEN-1:0]    mepc_q, mepc_d;
  logic [`ZR_CAUSE_W-1:0] mcause_q, mcause_d;

  //////////////////////////////////////////////////
  // next state
  always_comb begin
    mie_d    = mie_q;
    mpie_d   = mpie_q;
    mepc_d   = mepc_q;
    mcause_d = mcause_q;

    // software path first
    if (wen_i.mstatus) begin
      mie_d  = wdata_i[3];
      mpie_d = wdata_i[7];
    end
    if (wen_i.mepc)   mepc_d   = wdata_i;
    if (wen_i.mcause) mcause_d = {wdata_i[31], wdata_i[4:0]};  // irq flag + code

    // exception controller overrides the same fields
    if (trap_i.save_cause) begin
      if (trap_i.save_if) begin
        mepc_d = pc_if_i;  // faulting fetch
      end else if (trap_i.save_id) begin
        mepc_d = pc_id_i;  // instruction in decode
      end
      mpie_d   = mie_q;   // stack the enable
      mie_d    = 1'b0;    // irqs off in handler
      mcause_d = trap_i.cause;
    end else if (trap_i.restore_mret) begin
      mie_d  = mpie_q;    // pop the enable
      mpie_d = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      mie_q    <= mie_d;
      mpie_q   <= mpie_d;
      mepc_q   <= mepc_d;
      mcause_q <= mcause_d;
    end
  end

  // view for readback and core outputs
  always_comb begin
    mach_o.mie    = mie_q;
    mach_o.mpie   = mpie_q;
    mach_o.mepc   = mepc_q;
    mach_o.mcause = mcause_q;
  end

endmodule

// File: source/perf_cfg_regs.sv
//////////////////////////////////////////////////
// event enable and mode registers of the counters
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "zr_csr_settings.svh"

module perf_cfg_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  zr_csr_pkg::csr_wen_t   wen_i,
  input  logic [`ZR_XLEN-1:0]    wdata_i,
  output logic [`ZR_N_PERF-1:0]  pcer_o,  // one enable per counter
  output logic [1:0]             pcmr_o   // [0] global enable, [1] saturate
);

  logic [`ZR_N_PERF-1:0] pcer_q;
  logic [1:0]            pcmr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pcer_q <= '0;     // all events off
      pcmr_q <= 2'b11;  // counting on, saturating
    end else begin
      if (wen_i.pcer) pcer_q <= wdata_i[`ZR_N_PERF-1:0];
      if (wen_i.pcmr) pcmr_q <= wdata_i[1:0];
    end
  end

  assign pcer_o = pcer_q;
  assign pcmr_o = pcmr_q;

endmodule

// File: source/perf_counter_bank.sv
//////////////////////////////////////////////////
// six 32 bit event counters, increment requests are
// registered so a counter moves two edges after its event
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "zr_csr_settings.svh"

module perf_counter_bank (
  input  logic                                clk,
  input  logic                                rst_n,
  input  zr_csr_pkg::perf_event_t             perf_evt_i,
  input  logic [`ZR_N_PERF-1:0]               pcer_i,
  input  logic [1:0]                          pcmr_i,
  input  zr_csr_pkg::csr_wen_t                wen_i,
  input  logic [`ZR_XLEN-1:0]                 wdata_i,
  output logic [`ZR_N_PERF-1:0][`ZR_XLEN-1:0] pccr_o
);

  logic [`ZR_N_PERF-1:0]               cnt_in;  // raw event per counter
  logic [`ZR_N_PERF-1:0]               inc;
  logic [`ZR_N_PERF-1:0]               inc_q;   // registered request
  logic [`ZR_N_PERF-1:0][`ZR_XLEN-1:0] pccr_q;

  // counter map
  assign cnt_in = {perf_evt_i.branch_taken,  // 5 taken branches
                   perf_evt_i.branch,        // 4 branches
                   perf_evt_i.mem_store,     // 3 stores
                   perf_evt_i.mem_load,      // 2 loads
                   perf_evt_i.if_valid,      // 1 fetched instructions
                   1'b1};                    // 0 cycles

  assign inc = cnt_in & pcer_i & {`ZR_N_PERF{pcmr_i[0]}};

  //////////////////////////////////////////////////
  // request stage and counters
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inc_q  <= '0;
      pccr_q <= '0;
    end else begin
      inc_q <= inc;
      for (int i = 0; i < `ZR_N_PERF; i++) begin
        if (wen_i.pccr[i]) begin
          pccr_q[i] <= wdata_i;  // software beats the increment
        end else if (inc_q[i] && !(pcmr_i[1] && (&pccr_q[i]))) begin
          pccr_q[i] <= pccr_q[i] + 1'b1;  // wraps when not saturating
        end
      end
    end
  end

  assign pccr_o = pccr_q;

endmodule

// File: source/zr_csr_pkg.sv
//////////////////////////////////////////////////
// shared types of the CSR unit, opcodes and bundles
//////////////////////////////////////////////////

`include "zr_csr_settings.svh"

package zr_csr_pkg;

  // software access operation, encoding as driven by the decoder
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_H = 2'b10,
    PRIV_LVL_M = 2'b11  // only level this core runs in
  } priv_lvl_e;

  typedef struct packed {
    logic                  access;  // access strobe from the pipeline
    logic [`ZR_ADDR_W-1:0] addr;
    csr_op_e               op;
    logic [`ZR_XLEN-1:0]   wdata;
  } csr_req_t;

  // command from the exception controller
  typedef struct packed {
    logic                   save_cause;    // trap entry
    logic                   save_if;       // mepc from IF pc
    logic                   save_id;       // mepc from ID pc
    logic                   restore_mret;  // return from trap
    logic [`ZR_CAUSE_W-1:0] cause;
  } trap_ctrl_t;

  typedef struct packed {
    logic if_valid;
    logic mem_load;
    logic mem_store;
    logic branch;
    logic branch_taken;
  } perf_event_t;

  // one strobe per writable target
  typedef struct packed {
    logic                 mstatus;
    logic                 mepc;
    logic                 mcause;
    logic                 pcer;
    logic                 pcmr;
    logic [`ZR_N_PERF-1:0] pccr;  // per counter, all set for 0x79F
  } csr_wen_t;

  typedef struct packed {
    logic                   mie;
    logic                   mpie;
    logic [`ZR_XLEN-1:0]    mepc;
    logic [`ZR_CAUSE_W-1:0] mcause;
  } mach_view_t;

endpackage

// File: source/zr_csr_settings.svh
//////////////////////////////////////////////////
// fixed sizes and CSR map of the machine CSR unit
// include wherever a width or an address is needed
//////////////////////////////////////////////////

`ifndef ZR_CSR_SETTINGS_SVH
`define ZR_CSR_SETTINGS_SVH

// datapath and field widths
`define ZR_XLEN     32  // register and bus width
`define ZR_N_PERF   6   // cycles, fetch, load, store, branch, taken
`define ZR_ADDR_W   12  // CSR address space
`define ZR_CAUSE_W  6   // irq flag + 5 bit code
`define ZR_BOOT_W   24  // boot address, low byte implied zero

//////////////////////////////////////////////////
// machine mode registers
`define ZR_CSR_MSTATUS    12'h300
`define ZR_CSR_MTVEC      12'h305  // read only, from boot address
`define ZR_CSR_MEPC       12'h341
`define ZR_CSR_MCAUSE     12'h342
`define ZR_CSR_MHARTID    12'hF14  // read only, core and cluster id

// performance counter block
`define ZR_CSR_PCER       12'h7A0  // event enables
`define ZR_CSR_PCMR       12'h7A1  // global enable, saturation
`define ZR_CSR_PCCR_ALL   12'h79F  // write hits every counter
`define ZR_CSR_PCCR_BASE  12'h780  // counter i sits at base + i

`endif

// File: source/zr_csr_top.sv
//////////////////////////////////////////////////
// machine mode CSR unit top, wires the access path,
// machine registers and counter block together
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "zr_csr_settings.svh"

module zr_csr_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  zr_csr_pkg::csr_req_t     csr_req_i,
  input  zr_csr_pkg::trap_ctrl_t   trap_i,
  input  zr_csr_pkg::perf_event_t  perf_evt_i,
  input  logic [`ZR_XLEN-1:0]      pc_if_i,
  input  logic [`ZR_XLEN-1:0]      pc_id_i,
  input  logic [`ZR_BOOT_W-1:0]    boot_addr_i,
  input  logic [3:0]               core_id_i,
  input  logic [5:0]               cluster_id_i,
  output logic [`ZR_XLEN-1:0]      csr_rdata_o,
  output logic                     m_irq_enable_o,
  output logic [`ZR_XLEN-1:0]      mepc_o
);

  zr_csr_pkg::csr_wen_t                wen;    // per target strobes
  zr_csr_pkg::mach_view_t              mach;
  logic [`ZR_XLEN-1:0]                 wdata;  // after set/clear
  logic [`ZR_N_PERF-1:0]               pcer;
  logic [1:0]                          pcmr;
  logic [`ZR_N_PERF-1:0][`ZR_XLEN-1:0] pccr;

  csr_access_unit u_access (
    .csr_req_i    (csr_req_i),
    .mach_i       (mach),
    .pcer_i       (pcer),
    .pcmr_i       (pcmr),
    .pccr_i       (pccr),
    .boot_addr_i  (boot_addr_i),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .wen_o        (wen),
    .wdata_o      (wdata),
    .rdata_o      (csr_rdata_o)
  );

  machine_csr_regs u_mach (
    .clk     (clk),
    .rst_n   (rst_n),
    .wen_i   (wen),
    .wdata_i (wdata),
    .trap_i  (trap_i),
    .pc_if_i (pc_if_i),
    .pc_id_i (pc_id_i),
    .mach_o  (mach)
  );

  perf_cfg_regs u_perf_cfg (
    .clk     (clk),
    .rst_n   (rst_n),
    .wen_i   (wen),
    .wdata_i (wdata),
    .pcer_o  (pcer),
    .pcmr_o  (pcmr)
  );

  perf_counter_bank u_perf_cnt (
    .clk        (clk),
    .rst_n      (rst_n),
    .perf_evt_i (perf_evt_i),
    .pcer_i     (pcer),
    .pcmr_i     (pcmr),
    .wen_i      (wen),
    .wdata_i    (wdata),
    .pccr_o     (pccr)
  );

  // straight to the core
  assign m_irq_enable_o = mach.mie;
  assign mepc_o         = mach.mepc;

endmodule

// File: zr_csr.f
+incdir+source
source/zr_csr_pkg.sv
source/csr_access_unit.sv
source/machine_csr_regs.sv
source/perf_cfg_regs.sv
source/perf_counter_bank.sv
source/zr_csr_top.sv
bench/zr_csr_chk.sv
bench/zr_csr_tb.sv
